// File: fetch_cfg.svh
// fetch stage 2 configuration.
// widths, queue depth, control type codes and opcode values.
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

`define SIZE_PC           32
`define SIZE_INSTRUCTION  32
`define FETCH_BANDWIDTH   4
`define CTIQ_DEPTH        16
`define SIZE_CTI_LOG      4

// control types as stored in the CTI queue and sent to the predictor.
`define CTRL_RETURN       2'd0
`define CTRL_CALL         2'd1
`define CTRL_JUMP         2'd2
`define CTRL_COND         2'd3

// opcodes live in bits 31:24 of an instruction.
`define OPC_BRANCH        8'h01
`define OPC_JUMP          8'h02
`define OPC_CALL          8'h03
`define OPC_RETURN        8'h04

`endif

// File: fetchPkg.sv
// shared types of the fetch stage 2 front end.
// PCs, instructions, control types, queue tags and slot masks.
`include "fetch_cfg.svh"

package fetchPkg;

  // byte address of an instruction.
  typedef logic [`SIZE_PC-1:0]          pcT;

  // one raw instruction word.
  typedef logic [`SIZE_INSTRUCTION-1:0] instT;

  typedef logic [1:0]                   ctrlTypeT;   // one of the CTRL_* codes.

  // index of an entry in the CTI queue.
  typedef logic [`SIZE_CTI_LOG-1:0]     ctiTagT;

  typedef logic [`FETCH_BANDWIDTH-1:0]  slotMaskT;   // bit k belongs to slot k.

endpackage

// File: preDecode.sv
// predecoder for one fetch slot.
// finds control instructions, their type and their target address.
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module preDecode
(
  input  fetchPkg::pcT       pc_i,
  input  fetchPkg::instT     instruction_i,
  input  fetchPkg::pcT       btbTarget_i,
  output logic               isCtrl_o,
  output logic               isRtr_o,
  output fetchPkg::ctrlTypeT ctrlType_o,
  output fetchPkg::pcT       target_o
);
  import fetchPkg::*;

  logic [7:0] opcode;
  pcT         branchOffset;
  pcT         absTarget;

  assign opcode = instruction_i[31:24];

  // word offset turned into a signed byte offset.
  assign branchOffset = {{(`SIZE_PC-18){instruction_i[15]}}, instruction_i[15:0], 2'b00};
  assign absTarget    = {{(`SIZE_PC-26){1'b0}}, instruction_i[23:0], 2'b00};

  always_comb
  begin
    isCtrl_o   = 1'b1;
    isRtr_o    = 1'b0;
    ctrlType_o = `CTRL_JUMP;
    target_o   = pc_i + pcT'(4);   // fall through for anything that is not control.
    case (opcode)
      `OPC_BRANCH:
      begin
        ctrlType_o = `CTRL_COND;
        target_o   = pc_i + pcT'(4) + branchOffset;
      end
      `OPC_JUMP:
      begin
        target_o = absTarget;
      end
      `OPC_CALL:
      begin
        ctrlType_o = `CTRL_CALL;
        target_o   = absTarget;
      end
      `OPC_RETURN:
      begin
        // the return address is not in the word, so the BTB guess is passed on.
        isRtr_o    = 1'b1;
        ctrlType_o = `CTRL_RETURN;
        target_o   = btbTarget_i;
      end
      default:
        isCtrl_o = 1'b0;
    endcase
  end

endmodule

// File: ctiQueue.sv
// control-transfer queue of fetch stage 2.
// tags control instructions in fetch order, records their outcome from execute
// and sends one predictor update per committed entry.
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module ctiQueue
(
  input  logic               clk,
  input  logic               rst_i,
  input  logic               stall_i,
  input  logic               recoverFlag_i,
  input  logic               fs1Ready_i,
  input  fetchPkg::slotMaskT ctrlVector_i,
  input  fetchPkg::pcT       slotPc_i [0:`FETCH_BANDWIDTH-1],
  input  fetchPkg::ctrlTypeT slotCtrlType_i [0:`FETCH_BANDWIDTH-1],
  input  fetchPkg::ctiTagT   ctiQueueIndex_i,
  input  fetchPkg::pcT       resolvedTarget_i,
  input  logic               branchOutcome_i,
  input  logic               flagRecoverEX_i,
  input  logic               ctrlVerified_i,
  input  logic               commitCti_i,
  output fetchPkg::ctiTagT   slotTag_o [0:`FETCH_BANDWIDTH-1],
  output logic               full_o,
  output fetchPkg::pcT       updatePC_o,
  output fetchPkg::pcT       updateTarget_o,
  output fetchPkg::ctrlTypeT updateCtrlType_o,
  output logic               updateDir_o,
  output logic               updateEn_o
);
  import fetchPkg::*;

  ctiTagT                 head;
  ctiTagT                 tail;
  logic [`SIZE_CTI_LOG:0] occupancy;   // needs one bit more than a tag to hold 16.
  logic [`SIZE_CTI_LOG:0] numAlloc;
  logic [`SIZE_CTI_LOG:0] keptCount;

  logic allocEn;
  logic truncate;
  logic popEn;

  pcT       pcArr     [0:`CTIQ_DEPTH-1];
  pcT       targetArr [0:`CTIQ_DEPTH-1];
  ctrlTypeT typeArr   [0:`CTIQ_DEPTH-1];
  logic     dirArr    [0:`CTIQ_DEPTH-1];

  // each marked slot takes the tail plus the number of marked slots before it.
  always_comb
  begin
    ctiTagT nextTag;
    nextTag  = tail;
    numAlloc = '0;
    for (int k = 0; k < `FETCH_BANDWIDTH; k++)
    begin
      slotTag_o[k] = nextTag;
      if (ctrlVector_i[k])
      begin
        nextTag  = nextTag + 1'b1;
        numAlloc = numAlloc + 1'b1;
      end
    end
  end

  // full leaves room for one more whole bundle of control instructions.
  assign full_o = occupancy > (`CTIQ_DEPTH - `FETCH_BANDWIDTH);

  assign truncate = ctrlVerified_i & flagRecoverEX_i;
  assign allocEn  = fs1Ready_i & ~stall_i & ~full_o & ~truncate & ~recoverFlag_i;
  assign popEn    = commitCti_i & ~recoverFlag_i & (occupancy != '0);

  // a mispredicted entry stays, everything younger is dropped.
  assign keptCount = {1'b0, ctiQueueIndex_i - head} + 1'b1;

  always_ff @(posedge clk)
  begin
    if (rst_i)
    begin
      head      <= '0;
      tail      <= '0;
      occupancy <= '0;
    end
    else if (recoverFlag_i)
    begin
      tail      <= head;
      occupancy <= '0;
    end
    else
    begin
      if (popEn)
        head <= head + 1'b1;
      if (truncate)
      begin
        tail      <= ctiQueueIndex_i + 1'b1;
        occupancy <= keptCount - popEn;
      end
      else if (allocEn)
      begin
        tail      <= tail + numAlloc[`SIZE_CTI_LOG-1:0];
        occupancy <= occupancy + numAlloc - popEn;
      end
      else
      begin
        occupancy <= occupancy - popEn;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (!recoverFlag_i)
    begin
      for (int k = 0; k < `FETCH_BANDWIDTH; k++)
      begin
        if (allocEn && ctrlVector_i[k])
        begin
          pcArr[slotTag_o[k]]   <= slotPc_i[k];
          typeArr[slotTag_o[k]] <= slotCtrlType_i[k];
        end
      end
      if (ctrlVerified_i)
      begin
        targetArr[ctiQueueIndex_i] <= resolvedTarget_i;
        dirArr[ctiQueueIndex_i]    <= branchOutcome_i;
      end
    end
  end

  // the head entry is read out as it is popped.
  always_ff @(posedge clk)
  begin
    if (popEn)
    begin
      updatePC_o       <= pcArr[head];
      updateTarget_o   <= targetArr[head];
      updateCtrlType_o <= typeArr[head];
      updateDir_o      <= dirArr[head];
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst_i)
      updateEn_o <= 1'b0;
    else
      updateEn_o <= popEn;
  end

endmodule

// File: fetchStage2.sv
// second fetch stage of a four wide front end.
// predecodes the bundle, checks BTB guesses, cuts the bundle after the first
// redirecting slot and tags control instructions in the CTI queue.
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module fetchStage2
(
  input  logic                                          clk,
  input  logic                                          rst_i,
  input  logic                                          fs1Ready_i,
  input  fetchPkg::pcT                                  pc_i,
  input  logic [`SIZE_INSTRUCTION*`FETCH_BANDWIDTH-1:0] instructionBundle_i,
  input  fetchPkg::slotMaskT                            btbHit_i,
  input  fetchPkg::pcT                                  btbTarget_i [0:`FETCH_BANDWIDTH-1],
  input  fetchPkg::slotMaskT                            prediction_i,
  input  fetchPkg::pcT                                  rasAddr_i,
  input  logic                                          stall_i,
  input  logic                                          recoverFlag_i,
  input  fetchPkg::ctiTagT                              ctiQueueIndex_i,
  input  fetchPkg::pcT                                  resolvedTarget_i,
  input  logic                                          branchOutcome_i,
  input  logic                                          flagRecoverEX_i,
  input  logic                                          ctrlVerified_i,
  input  logic                                          commitCti_i,
  output fetchPkg::slotMaskT                            slotValid_o,
  output fetchPkg::instT                                slotInst_o [0:`FETCH_BANDWIDTH-1],
  output fetchPkg::pcT                                  slotPc_o [0:`FETCH_BANDWIDTH-1],
  output fetchPkg::pcT                                  slotTarget_o [0:`FETCH_BANDWIDTH-1],
  output fetchPkg::ctiTagT                              slotTag_o [0:`FETCH_BANDWIDTH-1],
  output fetchPkg::slotMaskT                            slotPrediction_o,
  output logic                                          flagRecoverID_o,
  output fetchPkg::pcT                                  targetAddrID_o,
  output logic                                          flagRtrID_o,
  output logic                                          flagCallID_o,
  output fetchPkg::pcT                                  callPCID_o,
  output fetchPkg::pcT                                  updatePC_o,
  output fetchPkg::pcT                                  updateTarget_o,
  output fetchPkg::ctrlTypeT                            updateCtrlType_o,
  output logic                                          updateDir_o,
  output logic                                          updateEn_o,
  output logic                                          fs2Ready_o,
  output logic                                          ctiQueueFull_o
);
  import fetchPkg::*;

  pcT       target   [0:`FETCH_BANDWIDTH-1];
  ctrlTypeT ctrlType [0:`FETCH_BANDWIDTH-1];
  slotMaskT isCtrl;
  slotMaskT isRtr;
  slotMaskT redirect;
  slotMaskT ctrlVector;

  logic redirectReq;
  pcT   selPc;
  pcT   selTarget;
  logic selMiss;
  logic selRtr;
  logic selCall;
  logic queueFull;

  for (genvar k = 0; k < `FETCH_BANDWIDTH; k++)
  begin : gSlot
    assign slotPc_o[k]   = pc_i + pcT'(4 * k);
    assign slotInst_o[k] = instructionBundle_i[k*`SIZE_INSTRUCTION +: `SIZE_INSTRUCTION];

    preDecode preDecodeInst
    (
      .pc_i          (slotPc_o[k]),
      .instruction_i (slotInst_o[k]),
      .btbTarget_i   (btbTarget_i[k]),
      .isCtrl_o      (isCtrl[k]),
      .isRtr_o       (isRtr[k]),
      .ctrlType_o    (ctrlType[k]),
      .target_o      (target[k])
    );

    // only a predicted not taken branch lets fetch fall through.
    assign redirect[k] = isCtrl[k] & ((ctrlType[k] != `CTRL_COND) | prediction_i[k]);

    // a valid return is always the cutting slot, so the RAS fills in its target.
    assign slotTarget_o[k] = (isRtr[k] & ~btbHit_i[k] & slotValid_o[k]) ? rasAddr_i : target[k];
  end

  // the first redirecting slot is the last valid one.
  always_comb
  begin
    logic cut;
    cut         = 1'b0;
    slotValid_o = '0;
    selPc       = slotPc_o[0];
    selTarget   = target[0];
    selMiss     = 1'b0;
    selRtr      = 1'b0;
    selCall     = 1'b0;
    for (int k = 0; k < `FETCH_BANDWIDTH; k++)
    begin
      slotValid_o[k] = ~cut;
      if (redirect[k] && !cut)
      begin
        cut       = 1'b1;
        selPc     = slotPc_o[k];
        selTarget = target[k];
        selMiss   = ~btbHit_i[k];
        selRtr    = isRtr[k];
        selCall   = ctrlType[k] == `CTRL_CALL;
      end
    end
  end

  assign ctrlVector  = slotValid_o & isCtrl;
  assign redirectReq = selMiss;   // fetch 1 followed the wrong path.

  assign flagRtrID_o     = redirectReq & selRtr;
  assign flagCallID_o    = redirectReq & selCall;
  assign flagRecoverID_o = redirectReq & ~stall_i & ~queueFull;
  assign targetAddrID_o  = flagRtrID_o ? rasAddr_i : selTarget;
  assign callPCID_o      = selPc;

  assign slotPrediction_o = prediction_i;
  assign ctiQueueFull_o   = queueFull;
  assign fs2Ready_o       = fs1Ready_i & ~queueFull;

  ctiQueue ctiQueueInst
  (
    .clk              (clk),
    .rst_i            (rst_i),
    .stall_i          (stall_i),
    .recoverFlag_i    (recoverFlag_i),
    .fs1Ready_i       (fs1Ready_i),
    .ctrlVector_i     (ctrlVector),
    .slotPc_i         (slotPc_o),
    .slotCtrlType_i   (ctrlType),
    .ctiQueueIndex_i  (ctiQueueIndex_i),
    .resolvedTarget_i (resolvedTarget_i),
    .branchOutcome_i  (branchOutcome_i),
    .flagRecoverEX_i  (flagRecoverEX_i),
    .ctrlVerified_i   (ctrlVerified_i),
    .commitCti_i      (commitCti_i),
    .slotTag_o        (slotTag_o),
    .full_o           (queueFull),
    .updatePC_o       (updatePC_o),
    .updateTarget_o   (updateTarget_o),
    .updateCtrlType_o (updateCtrlType_o),
    .updateDir_o      (updateDir_o),
    .updateEn_o       (updateEn_o)
  );

endmodule

// File: fetchStage2_assertions.sv
// bound assertions for fetch stage 2.
// check CTI queue occupancy, the update strobe after reset and redirect gating.
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module fetchStage2_assertions
(
  input logic                   clk,
  input logic                   rst_i,
  input logic                   stall_i,
  input logic [`SIZE_CTI_LOG:0] occupancy_i,
  input logic                   updateEn_i,
  input logic                   flagRecoverID_i
);
  import fetchPkg::*;

  occupancyBound: assert property (@(posedge clk) disable iff (rst_i)
    occupancy_i <= `CTIQ_DEPTH)
    else $error("CTI queue holds %0d entries, more than its depth", occupancy_i);

  // no update may leave the queue in the cycle after a reset edge.
  updateQuietAfterReset: assert property (@(posedge clk) rst_i |=> !updateEn_i)
    else $error("predictor update strobe high right after reset");

  noRedirectInStall: assert property (@(posedge clk) disable iff (rst_i)
    stall_i |-> !flagRecoverID_i)
    else $error("redirect request left the stage during a stall");

endmodule

// the occupancy comes from the queue inside the stage, the redirect flag from the top.
bind fetchStage2 fetchStage2_assertions assertInst
(
  .clk             (clk),
  .rst_i           (rst_i),
  .stall_i         (stall_i),
  .occupancy_i     (ctiQueueInst.occupancy),
  .updateEn_i      (updateEn_o),
  .flagRecoverID_i (flagRecoverID_o)
);

// File: fetchStage2Tb.sv
// directed testbench of fetch stage 2.
// checks predecode, bundle cutting, redirects and the CTI queue against a model.
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module fetchStage2Tb;
  import fetchPkg::*;

  localparam int NB          = `FETCH_BANDWIDTH;
  localparam int FULL_LEVEL  = `CTIQ_DEPTH - `FETCH_BANDWIDTH;
  localparam int TEST_CYCLES = 2 + 8 + 4 + 4 + 7 + 12 + 5;   // reset plus tests 1 to 6.
  localparam int TIMEOUT_NS  = (TEST_CYCLES + 50) * 20;

  logic clk = 1'b0;
  logic rst_i, fs1Ready_i, stall_i, recoverFlag_i;
  logic branchOutcome_i, flagRecoverEX_i, ctrlVerified_i, commitCti_i;
  logic [`SIZE_INSTRUCTION*NB-1:0] instructionBundle_i;
  pcT       pc_i, rasAddr_i, resolvedTarget_i;
  pcT       btbTarget_i [0:NB-1];
  slotMaskT btbHit_i, prediction_i;
  ctiTagT   ctiQueueIndex_i;

  slotMaskT slotValid_o, slotPrediction_o;
  instT     slotInst_o [0:NB-1];
  pcT       slotPc_o [0:NB-1];
  pcT       slotTarget_o [0:NB-1];
  ctiTagT   slotTag_o [0:NB-1];
  logic     flagRecoverID_o, flagRtrID_o, flagCallID_o;
  logic     updateDir_o, updateEn_o, fs2Ready_o, ctiQueueFull_o;
  pcT       targetAddrID_o, callPCID_o, updatePC_o, updateTarget_o;
  ctrlTypeT updateCtrlType_o;

  // model of the bundle and the queue.
  instT     slotWord [0:NB-1];
  pcT       modelPc [0:`CTIQ_DEPTH-1];
  pcT       modelTarget [0:`CTIQ_DEPTH-1];
  ctrlTypeT modelType [0:`CTIQ_DEPTH-1];
  logic     modelDir [0:`CTIQ_DEPTH-1];
  ctiTagT   modelHead, modelTail;
  int       modelCount;
  logic     updPending, updDir;
  pcT       updPc, updTarget;
  ctrlTypeT updType;
  int       errorCount, testErrors, testsRun, testsFailed;

  fetchStage2 UUT (.*);

  always #10 clk = ~clk;

  function automatic instT makeInst(logic [7:0] opcode, logic [23:0] field);
    return {opcode, field};
  endfunction

  function automatic instT fillerInst();
    return makeInst(8'h10 + 8'($urandom % 200), 24'($urandom));
  endfunction

  function automatic logic isControl(instT w);
    return w[31:24] inside {`OPC_BRANCH, `OPC_JUMP, `OPC_CALL, `OPC_RETURN};
  endfunction

  function automatic ctrlTypeT typeOf(instT w);
    case (w[31:24])
      `OPC_BRANCH: return `CTRL_COND;
      `OPC_CALL:   return `CTRL_CALL;
      `OPC_RETURN: return `CTRL_RETURN;
      default:     return `CTRL_JUMP;
    endcase
  endfunction

  // branches are PC relative in words, jumps and calls absolute in words.
  function automatic pcT targetOf(pcT pc, instT w, pcT btbGuess);
    int offset;
    offset = int'($signed(w[15:0]));
    case (w[31:24])
      `OPC_BRANCH: return pc + 32'd4 + pcT'(offset * 4);
      `OPC_RETURN: return btbGuess;
      default:     return pcT'(w[23:0]) * 4;
    endcase
  endfunction

  // index of the first slot that redirects fetch, NB when none does.
  function automatic int cutSlot();
    for (int k = 0; k < NB; k++)
      if (isControl(slotWord[k]) && (typeOf(slotWord[k]) != `CTRL_COND || prediction_i[k]))
        return k;
    return NB;
  endfunction

  function automatic pcT slotTargetRef(int k, logic miss);
    if (miss && typeOf(slotWord[k]) == `CTRL_RETURN)
      return rasAddr_i;
    return targetOf(pc_i + pcT'(4 * k), slotWord[k], btbTarget_i[k]);
  endfunction

  task automatic checkValue(string testName, string field, logic [63:0] expected,
                            logic [63:0] actual);
    if (actual !== expected)
    begin
      $display("CHECK FAILED %s: %s expected %h actual %h", testName, field, expected, actual);
      errorCount++;
      testErrors++;
    end
  endtask

  task automatic loadBundle(pcT pc);
    for (int k = 0; k < NB; k++)
      instructionBundle_i[k*`SIZE_INSTRUCTION +: `SIZE_INSTRUCTION] = slotWord[k];
    pc_i = pc;
  endtask

  task automatic checkOutputs(string testName);
    int     r;
    logic   miss, full, isRet, isCall;
    ctiTagT tag;
    r      = cutSlot();
    full   = modelCount > FULL_LEVEL;
    miss   = (r < NB) && !btbHit_i[r];
    isRet  = 1'b0;
    isCall = 1'b0;
    tag    = modelTail;
    for (int k = 0; k < NB; k++)
    begin
      checkValue(testName, "slot pc", pc_i + pcT'(4 * k), slotPc_o[k]);
      checkValue(testName, "slot instruction", slotWord[k], slotInst_o[k]);
      checkValue(testName, "slot valid", k <= r, slotValid_o[k]);
      if (k <= r && isControl(slotWord[k]))
      begin
        checkValue(testName, "slot target", slotTargetRef(k, k == r && miss), slotTarget_o[k]);
        checkValue(testName, "slot tag", tag, slotTag_o[k]);
        tag++;   // tags follow each other in slot order.
      end
    end
    if (r < NB)
    begin
      isRet  = typeOf(slotWord[r]) == `CTRL_RETURN;
      isCall = typeOf(slotWord[r]) == `CTRL_CALL;
      checkValue(testName, "redirect target", slotTargetRef(r, miss), targetAddrID_o);
      checkValue(testName, "call pc", pc_i + pcT'(4 * r), callPCID_o);
    end
    checkValue(testName, "return flag", miss && isRet, flagRtrID_o);
    checkValue(testName, "call flag", miss && isCall, flagCallID_o);
    checkValue(testName, "recover flag", miss && !stall_i && !full, flagRecoverID_o);
    checkValue(testName, "prediction", prediction_i, slotPrediction_o);
    checkValue(testName, "queue full", full, ctiQueueFull_o);
    checkValue(testName, "fs2 ready", fs1Ready_i && !full, fs2Ready_o);
    checkValue(testName, "update enable", updPending, updateEn_o);
    if (updPending)
    begin
      checkValue(testName, "update pc", updPc, updatePC_o);
      checkValue(testName, "update target", updTarget, updateTarget_o);
      checkValue(testName, "update type", updType, updateCtrlType_o);
      checkValue(testName, "update direction", updDir, updateDir_o);
    end
  endtask

  // applies the queue rules for the inputs of the current cycle.
  task automatic advanceModel();
    int   r;
    logic full, trunc, alloc, pop;
    r     = cutSlot();
    full  = modelCount > FULL_LEVEL;
    trunc = ctrlVerified_i && flagRecoverEX_i;
    alloc = fs1Ready_i && !stall_i && !full && !trunc && !recoverFlag_i;
    pop   = commitCti_i && !recoverFlag_i && modelCount != 0;
    updPending = pop;
    if (pop)
    begin
      updPc     = modelPc[modelHead];
      updTarget = modelTarget[modelHead];
      updType   = modelType[modelHead];
      updDir    = modelDir[modelHead];
    end
    if (recoverFlag_i)
    begin
      modelTail  = modelHead;
      modelCount = 0;
    end
    else
    begin
      if (ctrlVerified_i)
      begin
        modelTarget[ctiQueueIndex_i] = resolvedTarget_i;
        modelDir[ctiQueueIndex_i]    = branchOutcome_i;
      end
      if (trunc)
      begin
        modelTail  = ctiQueueIndex_i + 1'b1;
        modelCount = int'(ctiTagT'(ctiQueueIndex_i - modelHead)) + 1;
      end
      else if (alloc)
      begin
        for (int k = 0; k <= r && k < NB; k++)
        begin
          if (isControl(slotWord[k]))
          begin
            modelPc[modelTail]   = pc_i + pcT'(4 * k);
            modelType[modelTail] = typeOf(slotWord[k]);
            modelTail++;
            modelCount++;
          end
        end
      end
      if (pop)
      begin
        modelHead++;
        modelCount--;
      end
    end
  endtask

  task automatic runCycle(string testName);
    #2;
    checkOutputs(testName);
    advanceModel();
    @(posedge clk);
    #1;
  endtask

  task automatic finishTest(string testName);
    testsRun++;
    if (testErrors == 0)
      $display("test %s: ok", testName);
    else
    begin
      $display("test %s: %0d failed checks", testName, testErrors);
      testsFailed++;
    end
    testErrors = 0;
  endtask

  task automatic testPredecode();
    int sel;
    for (int i = 0; i < 8; i++)
    begin
      for (int k = 0; k < NB; k++)
      begin
        sel = $urandom % 5;
        case (sel)
          0: slotWord[k] = fillerInst();
          1: slotWord[k] = makeInst(`OPC_BRANCH, {8'h00, 16'($urandom % 2048)});
          2: slotWord[k] = makeInst(`OPC_BRANCH, {8'h00, 16'h8000 | 16'($urandom)});
          3: slotWord[k] = makeInst(`OPC_JUMP, 24'($urandom));
          default: slotWord[k] = makeInst(`OPC_CALL, 24'($urandom));
        endcase
        btbTarget_i[k] = $urandom & ~32'h3;
      end
      prediction_i = slotMaskT'($urandom);
      btbHit_i     = '1;
      loadBundle($urandom & ~32'h3);
      runCycle("predecode");
    end
    finishTest("predecode");
  endtask

  task automatic testBundleCut();
    for (int r = 0; r < NB; r++)
    begin
      for (int k = 0; k < NB; k++)
        slotWord[k] = fillerInst();
      if (r > 0)
        slotWord[0] = makeInst(`OPC_BRANCH, 24'h000010);   // not taken, so it must not cut.
      slotWord[r] = (r % 2) ? makeInst(`OPC_JUMP, 24'($urandom))
                            : makeInst(`OPC_BRANCH, 24'h00fff0);
      if (r < NB - 1)
        slotWord[NB-1] = makeInst(`OPC_CALL, 24'h000100);
      prediction_i = slotMaskT'(1 << r);
      btbHit_i     = '1;
      loadBundle($urandom & ~32'h3);
      runCycle("bundle cut");
    end
    finishTest("bundle cut");
  endtask

  task automatic testBtbMiss();
    for (int k = 0; k < NB; k++)
      slotWord[k] = fillerInst();
    rasAddr_i    = $urandom & ~32'h3;
    prediction_i = '0;
    slotWord[1]  = makeInst(`OPC_RETURN, 24'h0);
    btbHit_i     = 4'b1101;
    loadBundle($urandom & ~32'h3);
    runCycle("btb miss");
    slotWord[1] = fillerInst();
    slotWord[2] = makeInst(`OPC_CALL, 24'($urandom));
    btbHit_i    = 4'b1011;
    loadBundle($urandom & ~32'h3);
    runCycle("btb miss");
    slotWord[2] = makeInst(`OPC_RETURN, 24'h0);   // a hit keeps the BTB target.
    btbHit_i    = '1;
    loadBundle($urandom & ~32'h3);
    runCycle("btb miss");
    slotWord[2] = makeInst(`OPC_CALL, 24'($urandom));
    btbHit_i    = 4'b1011;
    stall_i     = 1'b1;
    loadBundle($urandom & ~32'h3);
    runCycle("btb miss");
    stall_i = 1'b0;
    finishTest("btb miss");
  endtask

  task automatic testTagAlloc();
    slotWord[0]  = makeInst(`OPC_BRANCH, 24'h000020);
    slotWord[1]  = fillerInst();
    slotWord[2]  = makeInst(`OPC_BRANCH, 24'h00ff00);
    slotWord[3]  = makeInst(`OPC_CALL, 24'h001234);
    prediction_i = '0;
    btbHit_i     = '1;
    fs1Ready_i   = 1'b1;
    // three entries per bundle, so the fifth bundle fills the queue.
    for (int i = 0; i < 7; i++)
    begin
      loadBundle($urandom & ~32'h3);
      runCycle("tag alloc");
    end
    checkValue("tag alloc", "queue full at end", 1'b1, ctiQueueFull_o);
    checkValue("tag alloc", "fs2 ready at end", 1'b0, fs2Ready_o);
    fs1Ready_i = 1'b0;
    finishTest("tag alloc");
  endtask

  task automatic testResolveCommit();
    ctrlVerified_i = 1'b1;
    for (int i = 0; i < 4; i++)
    begin
      ctiQueueIndex_i  = modelHead + ctiTagT'(i);
      resolvedTarget_i = $urandom & ~32'h3;
      branchOutcome_i  = 1'($urandom);
      runCycle("resolve commit");
    end
    ctrlVerified_i = 1'b0;
    for (int i = 0; i < 4; i++)
    begin
      commitCti_i = 1'b1;
      runCycle("resolve commit");
      commitCti_i = 1'b0;
      runCycle("resolve commit");
    end
    finishTest("resolve commit");
  endtask

  task automatic testRecovery();
    ctiTagT expectedTag;
    fs1Ready_i       = 1'b1;
    expectedTag      = modelHead + 3;
    ctrlVerified_i   = 1'b1;
    flagRecoverEX_i  = 1'b1;
    ctiQueueIndex_i  = modelHead + 2;
    resolvedTarget_i = $urandom & ~32'h3;
    branchOutcome_i  = 1'b1;
    runCycle("recovery");
    checkValue("recovery", "tag after truncation", expectedTag, slotTag_o[0]);
    ctrlVerified_i  = 1'b0;
    flagRecoverEX_i = 1'b0;
    runCycle("recovery");
    expectedTag   = modelHead;
    recoverFlag_i = 1'b1;
    runCycle("recovery");
    checkValue("recovery", "tag after flush", expectedTag, slotTag_o[0]);
    recoverFlag_i = 1'b0;
    runCycle("recovery");
    fs1Ready_i = 1'b0;
    runCycle("recovery");
    finishTest("recovery");
  endtask

  initial
  begin
    void'($urandom(32'h49077a37));
    rst_i = 1'b1;
    fs1Ready_i = 1'b0;
    stall_i = 1'b0;
    recoverFlag_i = 1'b0;
    branchOutcome_i = 1'b0;
    flagRecoverEX_i = 1'b0;
    ctrlVerified_i = 1'b0;
    commitCti_i = 1'b0;
    rasAddr_i = '0;
    resolvedTarget_i = '0;
    btbHit_i = '1;
    prediction_i = '0;
    ctiQueueIndex_i = '0;
    for (int k = 0; k < NB; k++)
    begin
      slotWord[k] = '0;
      btbTarget_i[k] = '0;
    end
    loadBundle('0);
    modelHead = '0;
    modelTail = '0;
    modelCount = 0;
    updPending = 1'b0;
    errorCount = 0;
    testErrors = 0;
    testsRun = 0;
    testsFailed = 0;
    repeat (2) @(posedge clk);
    #1;
    rst_i = 1'b0;
    testPredecode();
    testBundleCut();
    testBtbMiss();
    testTagAlloc();
    testResolveCommit();
    testRecovery();
    $display("%0d tests run, %0d tests failed, %0d failed checks",
             testsRun, testsFailed, errorCount);
    if (errorCount == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

  initial
  begin
    #(TIMEOUT_NS);
    $display("timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// File: verilog.f
+incdir+.
fetchPkg.sv
preDecode.sv
ctiQueue.sv
fetchStage2.sv
fetchStage2_assertions.sv
fetchStage2Tb.sv
